//--- sim.f
uartPkg.sv
baudTickGen.sv
uartReceiver.sv
uartTransmitter.sv
rxFifo.sv
selfTestCtrl.sv
uartCore.sv
uartTb.sv

//--- Bender.yml
package:
  name: uart_core

sources:
  - uartPkg.sv
  - baudTickGen.sv
  - uartReceiver.sv
  - uartTransmitter.sv
  - rxFifo.sv
  - selfTestCtrl.sv
  - uartCore.sv
  - target: test
    files:
      - uartTb.sv

//--- uartTb.sv
`timescale 1ns/1ps
`default_nettype none

module uartTb;

	localparam int bitCycles = uartPkg::overSample * uartPkg::tickDiv;	// 64 SysClk per bit
	localparam int frameCycles = 11 * bitCycles;
	localparam int watchdogCycles = 2 * 40 * frameCycles;	// Twice the length of 40 frames

	logic SysClk;
	logic arstN;
	logic rx;
	logic cts;
	logic start;
	logic bistStart;
	logic readDone;
	uartPkg::uartByte_t txData;
	logic tx;
	logic txBusy;
	logic rts;
	logic rxError;
	uartPkg::uartByte_t dataOut;
	logic fifoEmpty;
	logic fifoFull;
	logic fifoOverflow;
	logic bistBusy;
	logic bistError;

	logic [31:0] lfsr = 32'h4c305d1e;	// Fixed seed
	uartPkg::uartByte_t model [$];		// Expected FIFO contents
	logic overflowExp = 1'b0;
	int rxErrPulses = 0;
	int errCount = 0;
	int testBase = 0;			// errCount when the current test began
	int passCnt = 0;
	int failCnt = 0;
	int errBase;
	int k;
	logic [31:0] r;
	uartPkg::uartByte_t b;

	uartCore u_dut (.SysClk, .arstN, .rx, .cts, .start, .bistStart, .readDone, .txData,
		.tx, .txBusy, .rts, .rxError, .dataOut, .fifoEmpty, .fifoFull, .fifoOverflow,
		.bistBusy, .bistError);

	initial begin
		SysClk = 1'b0;
		forever #5 SysClk = ~SysClk;
	end

	always @(posedge SysClk) if (rxError) rxErrPulses <= rxErrPulses + 1;	// One per bad frame

	// ************************************************************************
	// Helpers
	// ************************************************************************
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		lfsrStep = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// Galois form shifting right
	endfunction

	task automatic randBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};	// One step per bit
			lfsr = lfsrStep(lfsr);
		end
	endtask

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic endTest(input string name);
		if (errCount == testBase) begin
			passCnt++;
			$display("Test %s: ok", name);
		end else begin
			failCnt++;
			$display("Test %s: %0d check(s) failed", name, errCount - testBase);
		end
		testBase = errCount;
	endtask

	// Holds one bit on rx for one bit time from a falling clock edge
	task automatic driveBit(input logic v);
		rx = v;
		repeat (bitCycles) @(negedge SysClk);
	endtask

	task automatic sendFrame(input uartPkg::uartByte_t data, input logic badParity,
		input logic badStop);
		driveBit(1'b0);				// Start
		for (int i = 0; i < uartPkg::dataBits; i++) driveBit(data[i]);	// LSB first
		if (uartPkg::parityEnable != 0) driveBit((^data) ^ badParity);	// Even parity
		for (int i = 0; i < uartPkg::stopBits; i++) driveBit(!(badStop && i == 0));
		rx = 1'b1;
	endtask

	// Samples tx in the middle of each bit of one frame
	task automatic watchFrame(input uartPkg::uartByte_t sent);
		uartPkg::uartByte_t data;
		data = '0;
		@(negedge tx);
		repeat (bitCycles / 2) @(negedge SysClk);
		checkVal("tx start bit", 0, tx);
		checkVal("txBusy", 1, txBusy);
		for (int i = 0; i < uartPkg::dataBits; i++) begin
			repeat (bitCycles) @(negedge SysClk);
			data[i] = tx;
			checkVal("txBusy", 1, txBusy);	// High all frame long
		end
		checkVal("tx data", sent, data);
		if (uartPkg::parityEnable != 0) begin
			repeat (bitCycles) @(negedge SysClk);
			checkVal("tx parity bit", ^sent, tx);	// Even parity of the byte sent
			checkVal("txBusy", 1, txBusy);
		end
		for (int i = 0; i < uartPkg::stopBits; i++) begin
			repeat (bitCycles) @(negedge SysClk);
			checkVal("tx stop bit", 1, tx);
			checkVal("txBusy", 1, txBusy);
		end
	endtask

	// Optional cts hold before the start is let in
	task automatic transmitByte(input uartPkg::uartByte_t v, input int holdCycles);
		txData = v;
		start = 1'b1;
		cts = (holdCycles == 0);
		repeat (holdCycles) begin
			@(negedge SysClk);
			checkVal("tx", 1, tx);		// No start bit while blocked
			checkVal("txBusy", 0, txBusy);
		end
		cts = 1'b1;
		@(negedge SysClk);
		start = 1'b0;
		checkVal("txBusy", 1, txBusy);		// One cycle after accept
		watchFrame(v);
		while (txBusy) @(negedge SysClk);
	endtask

	task automatic recordGood(input uartPkg::uartByte_t v);
		if (model.size() < uartPkg::fifoDepth) model.push_back(v);
		else overflowExp = 1'b1;		// Dropped by the FIFO
	endtask

	task automatic drainFifo();
		logic [31:0] gap;
		while (model.size() > 0) begin
			checkVal("fifoEmpty", 0, fifoEmpty);
			checkVal("dataOut", model[0], dataOut);
			readDone = 1'b1;
			@(negedge SysClk);
			readDone = 1'b0;
			void'(model.pop_front());
			randBits(3, gap);
			repeat (gap) @(negedge SysClk);
		end
		checkVal("fifoEmpty", 1, fifoEmpty);
	endtask

	task automatic runSelfTest();
		uartPkg::uartByte_t seq;
		seq = uartPkg::bistSeed;
		for (int i = 0; i < uartPkg::bistLength; i++) begin
			model.push_back(seq);
			seq = ((seq << 1) | (seq >> (uartPkg::dataBits - 1))) + 1'b1;	// Rotate left then add one
		end
		bistStart = 1'b1;
		@(negedge SysClk);
		bistStart = 1'b0;
		checkVal("bistBusy", 1, bistBusy);
		fork
			for (int i = 0; i < uartPkg::bistLength; i++) begin
				watchFrame(model[i]);
			end
			while (bistBusy) @(negedge SysClk);
		join
		checkVal("bistError", 0, bistError);
		drainFifo();
	endtask

	// ************************************************************************
	// Test sequence
	// ************************************************************************
	initial begin
		rx = 1'b1;				// Idle line
		cts = 1'b1;
		start = 1'b0;
		bistStart = 1'b0;
		readDone = 1'b0;
		txData = '0;
		arstN = 1'b0;
		repeat (16) @(negedge SysClk);
		arstN = 1'b1;
		@(negedge SysClk);

		checkVal("tx", 1, tx);
		checkVal("rts", 1, rts);
		checkVal("fifoEmpty", 1, fifoEmpty);
		checkVal("txBusy", 0, txBusy);
		checkVal("rxError", 0, rxError);
		checkVal("fifoFull", 0, fifoFull);
		checkVal("fifoOverflow", 0, fifoOverflow);
		checkVal("bistBusy", 0, bistBusy);
		checkVal("bistError", 0, bistError);
		endTest("1 reset values");

		for (k = 0; k < 5; k++) begin
			randBits(8, r);
			transmitByte(r[7:0], 0);
		end
		randBits(8, r);
		transmitByte(r[7:0], 3 * bitCycles);	// Sixth byte waits on cts
		endTest("2 transmit");

		for (k = 0; k < 5; k++) begin
			randBits(8, r);
			b = r[7:0];
			randBits(6, r);
			repeat (r) @(negedge SysClk);	// Random idle gap
			sendFrame(b, 1'b0, 1'b0);
			recordGood(b);
			checkVal("fifoEmpty", model.size() == 0, fifoEmpty);
		end
		drainFifo();
		endTest("3 receive");

		errBase = rxErrPulses;
		randBits(8, r);
		sendFrame(r[7:0], 1'b1, 1'b0);
		checkVal("rxError pulses", errBase + 1, rxErrPulses);
		checkVal("fifoEmpty", 1, fifoEmpty);
		randBits(8, r);
		sendFrame(r[7:0], 1'b0, 1'b1);
		checkVal("rxError pulses", errBase + 2, rxErrPulses);
		checkVal("fifoEmpty", 1, fifoEmpty);
		repeat (bitCycles) @(negedge SysClk);	// Line back high before the next start
		randBits(8, r);
		sendFrame(r[7:0], 1'b0, 1'b0);
		recordGood(r[7:0]);
		checkVal("rxError pulses", errBase + 2, rxErrPulses);
		drainFifo();
		endTest("4 line errors");

		for (k = 0; k < uartPkg::fifoDepth + 1; k++) begin
			randBits(8, r);
			sendFrame(r[7:0], 1'b0, 1'b0);
			recordGood(r[7:0]);
			checkVal("fifoFull", model.size() == uartPkg::fifoDepth, fifoFull);
			checkVal("rts", model.size() != uartPkg::fifoDepth, rts);
			checkVal("fifoOverflow", overflowExp, fifoOverflow);
		end
		drainFifo();
		checkVal("fifoOverflow", 1, fifoOverflow);	// Sticky
		endTest("5 FIFO limits");

		runSelfTest();
		endTest("6 self test");

		$display("Tests passed: %0d, failed: %0d, failed checks: %0d", passCnt, failCnt,
			errCount);
		if (errCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog bounds the whole run
	initial begin
		repeat (watchdogCycles) @(posedge SysClk);
		$display("Watchdog: the tests did not finish in the expected time, run stopped");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- uartCore.sv
`timescale 1ns/1ps
`default_nettype none

module uartCore (
	input  logic SysClk,
	input  logic arstN,
	input  logic rx,			// Serial in from the pin
	input  logic cts,
	input  logic start,			// Port transmit strobe
	input  logic bistStart,
	input  logic readDone,
	input  uartPkg::uartByte_t txData,
	output logic tx,
	output logic txBusy,
	output logic rts,
	output logic rxError,
	output uartPkg::uartByte_t dataOut,	// FIFO head
	output logic fifoEmpty,
	output logic fifoFull,
	output logic fifoOverflow,
	output logic bistBusy,
	output logic bistError
);

	logic sampleTick;
	logic rxIn;
	logic bistMode;
	uartPkg::txReq_t portReq;
	uartPkg::txReq_t bistReq;
	uartPkg::txReq_t txReq;
	uartPkg::rxBeat_t beat;			// To FIFO and self test

	// Loopback muxes
	assign portReq = '{start: start, data: txData};
	assign txReq = bistMode ? bistReq : portReq;
	assign rxIn = bistMode ? tx : rx;		// Self test listens to its own tx

	// ************************************************************************
	// Blocks
	// ************************************************************************
	baudTickGen baudGen (.SysClk, .arstN, .sampleTick);

	uartReceiver receiver (.SysClk, .arstN, .sampleTick, .rxIn, .fifoFull,
		.beat, .rxError, .rts);

	uartTransmitter transmitter (.SysClk, .arstN, .sampleTick, .req(txReq), .cts,
		.tx, .txBusy);

	rxFifo fifo (.SysClk, .arstN, .beat, .readDone, .dataOut, .fifoEmpty,
		.fifoFull, .fifoOverflow);

	selfTestCtrl selfTest (.SysClk, .arstN, .bistStart, .beat, .txBusy,
		.bistReq, .bistMode, .bistBusy, .bistError);

endmodule

`default_nettype wire

//--- selfTestCtrl.sv
`timescale 1ns/1ps
`default_nettype none

// Loopback self test, sends a byte sequence and checks it comes back
module selfTestCtrl (
	input  logic SysClk,
	input  logic arstN,
	input  logic bistStart,
	input  uartPkg::rxBeat_t beat,		// From the receiver
	input  logic txBusy,
	output uartPkg::txReq_t bistReq,	// To the transmitter mux
	output logic bistMode,			// Selects loopback paths
	output logic bistBusy,
	output logic bistError
);

	uartPkg::bistState_e state;
	uartPkg::bistCnt_t byteCnt;		// Bytes compared so far
	uartPkg::uartByte_t expected;		// Byte in flight
	logic reqOut;				// Held start strobe

	assign bistReq = '{start: reqOut, data: expected};

	// ************************************************************************
	// Sequencer
	// ************************************************************************
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			state <= uartPkg::bistIdle;
			byteCnt <= '0;
			reqOut <= 1'b0;
			bistMode <= 1'b0;
			bistBusy <= 1'b0;
			bistError <= 1'b0;
		end else begin
			case (state)
				uartPkg::bistIdle: if (bistStart) begin
					state <= uartPkg::bistSend;
					byteCnt <= '0;
					bistMode <= 1'b1;
					bistBusy <= 1'b1;
					bistError <= 1'b0;	// Fresh result each run
				end
				uartPkg::bistSend: begin
					if (reqOut && txBusy) begin	// Accepted
						reqOut <= 1'b0;
						state <= uartPkg::bistWaitRx;
					end else if (!txBusy) begin
						reqOut <= 1'b1;		// Hold until cts lets it in
					end
				end
				uartPkg::bistWaitRx: if (beat.rdy) begin
					if (beat.data != expected) bistError <= 1'b1;
					if (byteCnt == uartPkg::bistCnt_t'(uartPkg::bistLength - 1)) begin
						state <= uartPkg::bistDone;
					end else begin
						byteCnt <= byteCnt + 1'b1;
						state <= uartPkg::bistSend;
					end
				end
				uartPkg::bistDone: begin
					state <= uartPkg::bistIdle;
					bistMode <= 1'b0;	// Both drop together
					bistBusy <= 1'b0;
				end
				default: state <= uartPkg::bistIdle;
			endcase
		end
	end

	// Byte sequence, seed then rotate left and increment
	always_ff @(posedge SysClk) begin
		if (state == uartPkg::bistIdle && bistStart) begin
			expected <= uartPkg::bistSeed;
		end else if (state == uartPkg::bistWaitRx && beat.rdy) begin
			expected <= {expected[uartPkg::dataBits-2:0], expected[uartPkg::dataBits-1]}
				+ 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rxFifo.sv
`timescale 1ns/1ps
`default_nettype none

// First-word-fall-through receive buffer
module rxFifo (
	input  logic SysClk,
	input  logic arstN,
	input  uartPkg::rxBeat_t beat,		// Write on rdy
	input  logic readDone,			// Pop the head
	output uartPkg::uartByte_t dataOut,
	output logic fifoEmpty,
	output logic fifoFull,
	output logic fifoOverflow		// Sticky until reset
);

	localparam int ptrMsb = $bits(uartPkg::fifoPtr_t) - 1;

	uartPkg::uartByte_t mem [uartPkg::fifoDepth];
	uartPkg::fifoPtr_t wrPtr;
	uartPkg::fifoPtr_t rdPtr;
	logic push;
	logic pop;

	assign fifoEmpty = (wrPtr == rdPtr);
	assign fifoFull = (wrPtr[ptrMsb] != rdPtr[ptrMsb])
		&& (wrPtr[ptrMsb-1:0] == rdPtr[ptrMsb-1:0]);	// Wrapped once more
	assign dataOut = mem[rdPtr[ptrMsb-1:0]];		// Head shown without a read

	assign pop = readDone && !fifoEmpty;
	assign push = beat.rdy && (!fifoFull || pop);	// Pop frees the slot this cycle

	// ************************************************************************
	// Pointers and flags
	// ************************************************************************
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoOverflow <= 1'b0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			if (beat.rdy && !push) fifoOverflow <= 1'b1;	// Byte dropped
		end
	end

	// Storage
	always_ff @(posedge SysClk) begin
		if (push) begin
			mem[wrPtr[ptrMsb-1:0]] <= beat.data;
		end
	end

endmodule

`default_nettype wire

//--- uartTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uartTransmitter (
	input  logic SysClk,
	input  logic arstN,
	input  logic sampleTick,
	input  uartPkg::txReq_t req,		// Start strobe plus byte
	input  logic cts,			// Clear to send from the far end
	output logic tx,
	output logic txBusy
);

	uartPkg::txState_e state;
	uartPkg::tickCnt_t tickCnt;
	uartPkg::bitCnt_t bitCnt;
	uartPkg::uartByte_t shiftReg;		// Remaining data bits
	logic parityBit;
	logic accept;
	logic bitEnd;

	assign accept = (state == uartPkg::txIdle) && req.start && cts;	// txBusy low in idle
	assign bitEnd = sampleTick && (tickCnt == uartPkg::tickCnt_t'(uartPkg::overSample - 1));

	// ************************************************************************
	// Frame FSM, each bit held overSample ticks
	// ************************************************************************
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			state <= uartPkg::txIdle;
			tx <= 1'b1;
			txBusy <= 1'b0;
			tickCnt <= '0;
			bitCnt <= '0;
		end else begin
			if (sampleTick) tickCnt <= bitEnd ? '0 : tickCnt + 1'b1;
			case (state)
				uartPkg::txIdle: if (accept) begin
					state <= uartPkg::txWait;
					txBusy <= 1'b1;
				end
				uartPkg::txWait: if (sampleTick) begin	// Align to the tick
					state <= uartPkg::txStart;
					tx <= 1'b0;
					tickCnt <= '0;
				end
				uartPkg::txStart: if (bitEnd) begin
					state <= uartPkg::txData;
					tx <= shiftReg[0];
					bitCnt <= '0;
				end
				uartPkg::txData: if (bitEnd) begin
					if (bitCnt == uartPkg::bitCnt_t'(uartPkg::dataBits - 1)) begin
						bitCnt <= '0;
						if (uartPkg::parityEnable != 0) begin
							state <= uartPkg::txParity;
							tx <= parityBit;
						end else begin
							state <= uartPkg::txStop;
							tx <= 1'b1;
						end
					end else begin
						bitCnt <= bitCnt + 1'b1;
						tx <= shiftReg[1];	// Next bit before the shift lands
					end
				end
				uartPkg::txParity: if (bitEnd) begin
					state <= uartPkg::txStop;
					tx <= 1'b1;
				end
				uartPkg::txStop: if (bitEnd) begin
					if (bitCnt == uartPkg::bitCnt_t'(uartPkg::stopBits - 1)) begin
						state <= uartPkg::txIdle;
						txBusy <= 1'b0;	// Line stays high
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				default: state <= uartPkg::txIdle;
			endcase
		end
	end

	// Byte latch and shifter
	always_ff @(posedge SysClk) begin
		if (accept) begin
			shiftReg <= req.data;
			parityBit <= ^req.data;		// Even parity over data
		end else if (state == uartPkg::txData && bitEnd) begin
			shiftReg <= shiftReg >> 1;
		end
	end

endmodule

`default_nettype wire

//--- uartReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module uartReceiver (
	input  logic SysClk,
	input  logic arstN,
	input  logic sampleTick,
	input  logic rxIn,			// Serial input, pin or loopback
	input  logic fifoFull,
	output uartPkg::rxBeat_t beat,		// Good byte, one-cycle rdy
	output logic rxError,			// Parity or stop bit wrong
	output logic rts
);

	uartPkg::rxState_e state;
	logic [1:0] rxSync;			// Two-flop synchronizer
	logic rxS;				// Synchronized line
	logic rxPrev;				// For falling-edge detect
	uartPkg::tickCnt_t tickCnt;
	uartPkg::bitCnt_t bitCnt;
	uartPkg::uartByte_t shiftReg;
	logic parityAcc;			// Running XOR of data bits
	logic frameErr;
	logic rdyQ;
	logic midTick;
	logic bitEnd;

	assign rxS = rxSync[1];
	assign midTick = sampleTick && (tickCnt == uartPkg::tickCnt_t'(uartPkg::overSample/2 - 1));
	assign bitEnd = sampleTick && (tickCnt == uartPkg::tickCnt_t'(uartPkg::overSample - 1));

	assign beat = '{rdy: rdyQ, data: shiftReg};
	assign rts = (state == uartPkg::rxIdle) && !fifoFull;	// Ready for a new frame

	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			rxSync <= 2'b11;		// Idle line is high
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rxIn};
			rxPrev <= rxS;
		end
	end

	// ************************************************************************
	// Frame FSM, samples taken mid-bit
	// ************************************************************************
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			state <= uartPkg::rxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			parityAcc <= 1'b0;
			frameErr <= 1'b0;
			rdyQ <= 1'b0;
			rxError <= 1'b0;
		end else begin
			rdyQ <= 1'b0;			// Pulses by default
			rxError <= 1'b0;
			if (sampleTick) tickCnt <= bitEnd ? '0 : tickCnt + 1'b1;
			case (state)
				uartPkg::rxIdle: if (rxPrev && !rxS) begin
					state <= uartPkg::rxStart;
					tickCnt <= '0;		// Half-bit count starts at the edge
				end
				uartPkg::rxStart: if (midTick) begin
					if (!rxS) begin		// Still low, start bit confirmed
						state <= uartPkg::rxData;
						tickCnt <= '0;
						bitCnt <= '0;
						parityAcc <= 1'b0;
						frameErr <= 1'b0;
					end else begin
						state <= uartPkg::rxIdle;	// Glitch
					end
				end
				uartPkg::rxData: if (bitEnd) begin
					parityAcc <= parityAcc ^ rxS;
					if (bitCnt == uartPkg::bitCnt_t'(uartPkg::dataBits - 1)) begin
						bitCnt <= '0;
						state <= (uartPkg::parityEnable != 0) ? uartPkg::rxParity
							: uartPkg::rxStop;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				uartPkg::rxParity: if (bitEnd) begin
					frameErr <= frameErr | (parityAcc ^ rxS);	// Even: XOR must be 0
					state <= uartPkg::rxStop;
				end
				uartPkg::rxStop: if (bitEnd) begin
					if (bitCnt == uartPkg::bitCnt_t'(uartPkg::stopBits - 1)) begin
						state <= uartPkg::rxIdle;
						bitCnt <= '0;
						if (frameErr || !rxS) rxError <= 1'b1;
						else rdyQ <= 1'b1;
					end else begin
						bitCnt <= bitCnt + 1'b1;
						frameErr <= frameErr | !rxS;	// Earlier stop bit low
					end
				end
				default: state <= uartPkg::rxIdle;
			endcase
		end
	end

	// Data shift, LSB arrives first
	always_ff @(posedge SysClk) begin
		if (state == uartPkg::rxData && bitEnd) begin
			shiftReg <= {rxS, shiftReg[uartPkg::dataBits-1:1]};
		end
	end

endmodule

`default_nettype wire

//--- baudTickGen.sv
`timescale 1ns/1ps
`default_nettype none

// Sample tick enable at overSample times the baud rate
module baudTickGen (
	input  logic SysClk,
	input  logic arstN,
	output logic sampleTick		// One SysClk cycle wide
);

	uartPkg::divCnt_t divCnt;	// Cycles since last tick
	logic wrap;

	assign wrap = (divCnt == uartPkg::divCnt_t'(uartPkg::tickDiv - 1));

	// Modulo tickDiv counter, tick registered on the wrap
	always_ff @(posedge SysClk or negedge arstN) begin
		if (!arstN) begin
			divCnt <= '0;
			sampleTick <= 1'b0;
		end else begin
			sampleTick <= wrap;	// First tick tickDiv cycles after reset
			if (wrap) begin
				divCnt <= '0;
			end else begin
				divCnt <= divCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- uartPkg.sv
`default_nettype none

package uartPkg;

	// ************************************************************************
	// Timing
	// ************************************************************************
	localparam int sysClkRate = 6400000;		// SysClk frequency in Hz
	localparam int baudRate = 100000;		// Line rate
	localparam int overSample = 16;			// Sample ticks per bit
	localparam int tickDiv = sysClkRate / (baudRate * overSample);	// SysClk cycles per tick

	// ************************************************************************
	// Frame format
	// ************************************************************************
	localparam int dataBits = 8;			// LSB first on the line
	localparam int parityEnable = 1;		// 1 = even parity bit present
	localparam int stopBits = 1;

	// Receive buffering and self test
	localparam int fifoDepth = 8;			// Power of two
	localparam int bistLength = 4;			// Bytes per self-test run
	localparam logic [dataBits-1:0] bistSeed = 8'hA5;

	// Vector types
	typedef logic [dataBits-1:0] uartByte_t;
	typedef logic [$clog2(fifoDepth):0] fifoPtr_t;	// Extra MSB tells full from empty
	typedef logic [3:0] tickCnt_t;			// Ticks within one bit
	typedef logic [$clog2(dataBits)-1:0] bitCnt_t;	// Data / stop bit index
	typedef logic [$clog2(bistLength+1)-1:0] bistCnt_t;
	typedef logic [((tickDiv > 1) ? $clog2(tickDiv) : 1)-1:0] divCnt_t;

	// Transmit request, from the ports or from the self test
	typedef struct packed {
		logic start;
		uartByte_t data;
	} txReq_t;

	// One-cycle beat for a good received byte
	typedef struct packed {
		logic rdy;
		uartByte_t data;
	} rxBeat_t;

	typedef enum logic [2:0] {rxIdle, rxStart, rxData, rxParity, rxStop} rxState_e;
	typedef enum logic [2:0] {txIdle, txWait, txStart, txData, txParity, txStop} txState_e;
	typedef enum logic [1:0] {bistIdle, bistSend, bistWaitRx, bistDone} bistState_e;

endpackage

`default_nettype wire
